// File: logic/cnn_feed_pkg.sv
package cnn_feed_pkg;

    localparam int img_dim = 30;    // Frame side in pixels.
    localparam int pool_dim = 10;   // Pooling block side in pixels.
    localparam int pool_grid = img_dim / pool_dim;
    localparam int pool_blocks = pool_grid * pool_grid;
    localparam int seq_len = 4;     // Digit sequence slots.

    typedef logic [4:0] coord_t;
    typedef logic [3:0] digit_t;

    // Slot 0 sits in the low bits.
    typedef digit_t [seq_len-1:0] digit_seq_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        coord_t     x;
        coord_t     y;
        logic       last;   // Final pixel of the frame.
        digit_t     digit;
    } pix_beat_t;

    typedef logic [14:0] block_sum_t;   // Up to 100 pixels of 8'hff.

    // Sums in row-major block order with block (0,0) at index 0.
    typedef struct packed {
        block_sum_t [pool_blocks-1:0] sums;
        digit_t                       digit;
    } feature_t;

    // The write data is read as a gap or as a sequence by address.
    typedef union packed {
        logic [15:0] gap;
        digit_seq_t  seq;
    } cfg_word_u;

    typedef struct packed {
        logic      en;
        logic      addr;    // 0 gap, 1 sequence.
        cfg_word_u data;
    } cfg_wr_t;

endpackage

// File: logic/feed_config.sv
`timescale 1ns/1ps

module feed_config #(
    parameter logic [15:0] gap_reset = 16'd16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  cnn_feed_pkg::cfg_wr_t    cfg_wr,
    output logic [15:0]              gap_cycles,
    output cnn_feed_pkg::digit_seq_t digit_seq
);

    // Listed from slot 3 down to slot 0 for the order 1, 2, 8, 1.
    localparam cnn_feed_pkg::digit_seq_t seq_reset = {4'd1, 4'd8, 4'd2, 4'd1};

    logic gap_wr;
    logic seq_wr;

    assign gap_wr = cfg_wr.en && !cfg_wr.addr;
    assign seq_wr = cfg_wr.en && cfg_wr.addr;

    // Idle cycles between frames.
    always_ff @(posedge clk) begin
        if (rst) begin
            gap_cycles <= gap_reset;
        end else if (gap_wr) begin
            gap_cycles <= cfg_wr.data.gap;
        end
    end

    // Same word read through the sequence view.
    always_ff @(posedge clk) begin
        if (rst) begin
            digit_seq <= seq_reset;
        end else if (seq_wr) begin
            digit_seq <= cfg_wr.data.seq;
        end
    end

endmodule

// File: logic/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  cnn_feed_pkg::digit_t glyph_digit,
    input  cnn_feed_pkg::coord_t glyph_x,
    input  cnn_feed_pkg::coord_t glyph_y,
    output logic [7:0]           glyph_pix
);

    localparam int dim = cnn_feed_pkg::img_dim;

    // Row 0 is the top line and the leftmost bit is x = 0.
    localparam logic [0:dim-1][dim-1:0] glyph_one = '{
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0001110000_0000000000,
        30'b0000000000_0011110000_0000000000,
        30'b0000000000_0110110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_1111111111_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000
    };

    localparam logic [0:dim-1][dim-1:0] glyph_two = '{
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0111111110_0000000000,
        30'b0000000001_1000000001_1000000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000000_0000000000_1100000000,
        30'b0000000000_0000000001_1000000000,
        30'b0000000000_0000000011_0000000000,
        30'b0000000000_0000000110_0000000000,
        30'b0000000000_0000001100_0000000000,
        30'b0000000000_0000011000_0000000000,
        30'b0000000000_0000110000_0000000000,
        30'b0000000000_0001100000_0000000000,
        30'b0000000000_0011000000_0000000000,
        30'b0000000000_0110000000_0000000000,
        30'b0000000000_1100000000_0000000000,
        30'b0000000001_1000000000_0000000000,
        30'b0000000011_0000000000_0000000000,
        30'b0000000011_0000000000_0000000000,
        30'b0000000011_0000000000_0000000000,
        30'b0000000011_1111111111_1100000000,
        30'b0000000011_1111111111_1100000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000
    };

    localparam logic [0:dim-1][dim-1:0] glyph_eight = '{
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0111111110_0000000000,
        30'b0000000001_1000000001_1000000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000001_1000000001_1000000000,
        30'b0000000000_0111111110_0000000000,
        30'b0000000001_1000000001_1000000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000011_0000000000_1100000000,
        30'b0000000001_1000000001_1000000000,
        30'b0000000000_0111111110_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000,
        30'b0000000000_0000000000_0000000000
    };

    logic [dim-1:0] row;
    logic           lit;

    always_comb begin
        row = '0;
        lit = 1'b0;
        if (glyph_x < dim && glyph_y < dim) begin
            case (glyph_digit)
                4'd1:    row = glyph_one[glyph_y];
                4'd2:    row = glyph_two[glyph_y];
                4'd8:    row = glyph_eight[glyph_y];
                default: row = '0;   // No glyph gives a blank frame.
            endcase
            lit = row[dim - 1 - glyph_x];
        end
        glyph_pix = lit ? 8'hff : 8'h00;
    end

endmodule

// File: logic/raster_scan.sv
`timescale 1ns/1ps

module raster_scan #(
    parameter int credits = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [15:0]               gap_cycles,
    input  cnn_feed_pkg::digit_seq_t  digit_seq,
    output cnn_feed_pkg::digit_t      glyph_digit,
    output cnn_feed_pkg::coord_t      glyph_x,
    output cnn_feed_pkg::coord_t      glyph_y,
    input  logic [7:0]                glyph_pix,
    output cnn_feed_pkg::pix_beat_t   beat,
    input  logic                      credit_ret
);

    localparam int cred_w = $clog2(credits + 1);
    localparam int slot_w = $clog2(cnn_feed_pkg::seq_len);
    localparam cnn_feed_pkg::coord_t coord_max = cnn_feed_pkg::coord_t'(cnn_feed_pkg::img_dim - 1);

    logic                 scanning;     // Low during the gap.
    logic [15:0]          gap_cnt;
    logic [15:0]          gap_len;
    logic [slot_w-1:0]    slot;
    cnn_feed_pkg::digit_t frame_digit;
    cnn_feed_pkg::coord_t x;
    cnn_feed_pkg::coord_t y;
    logic [cred_w-1:0]    credit_cnt;
    logic                 send;
    logic                 frame_end;

    assign send = scanning && (credit_cnt != '0);
    assign frame_end = (x == coord_max) && (y == coord_max);

    assign glyph_digit = frame_digit;
    assign glyph_x = x;
    assign glyph_y = y;

    // Gap and sequence are sampled only when a frame starts.
    always_ff @(posedge clk) begin
        if (rst) begin
            scanning <= 1'b0;
            gap_cnt <= 16'd1;
            gap_len <= gap_cycles;
            slot <= '0;
            frame_digit <= '0;
            x <= '0;
            y <= '0;
        end else if (!scanning) begin
            if (gap_cnt >= gap_len) begin
                scanning <= 1'b1;
                gap_len <= gap_cycles;
                frame_digit <= digit_seq[slot];
                slot <= (slot == slot_w'(cnn_feed_pkg::seq_len - 1)) ? '0 : slot + 1'b1;
                x <= '0;
                y <= '0;
            end else begin
                gap_cnt <= gap_cnt + 16'd1;
            end
        end else if (send) begin
            if (x == coord_max) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
            if (frame_end) begin
                scanning <= 1'b0;
                gap_cnt <= 16'd1; // A zero gap still idles one cycle.
            end
        end
    end

    always_ff @(posedge clk) begin
        beat.data <= glyph_pix;
        beat.x <= x;
        beat.y <= y;
        beat.last <= frame_end;
        beat.digit <= frame_digit;
        if (rst) begin
            beat.valid <= 1'b0;
        end else begin
            beat.valid <= send;
        end
    end

    // Send and return together leave the count as is.
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= cred_w'(credits);
        end else if (send && !credit_ret) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!send && credit_ret) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

// File: logic/pool_sum.sv
`timescale 1ns/1ps

module pool_sum #(
    parameter int credits = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cnn_feed_pkg::pix_beat_t beat,
    output logic                    credit_ret,
    output cnn_feed_pkg::feature_t  feat,
    output logic                    feat_valid,
    input  logic                    feat_ready
);

    localparam int ptr_w = (credits > 1) ? $clog2(credits) : 1;
    localparam int cnt_w = $clog2(credits + 1);
    localparam int blk_w = $clog2(cnn_feed_pkg::pool_blocks);

    cnn_feed_pkg::pix_beat_t fifo_mem [credits];
    logic [ptr_w-1:0]        wr_ptr;
    logic [ptr_w-1:0]        rd_ptr;
    logic [cnt_w-1:0]        fifo_cnt;
    logic                    pop;
    cnn_feed_pkg::pix_beat_t stg;       // Popped beat that is summed next cycle.
    logic [blk_w-1:0]        stg_blk;

    cnn_feed_pkg::block_sum_t [cnn_feed_pkg::pool_blocks-1:0] acc;
    cnn_feed_pkg::block_sum_t [cnn_feed_pkg::pool_blocks-1:0] acc_next;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(credits - 1)) ? '0 : p + 1'b1;
    endfunction

    // Hold off while a feature waits, so credits drain and the sender stalls.
    assign pop = (fifo_cnt != '0) && !(feat_valid && !feat_ready);
    assign credit_ret = pop;

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            fifo_mem[wr_ptr] <= beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
        end else begin
            if (beat.valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (beat.valid && !pop) begin
                fifo_cnt <= fifo_cnt + 1'b1;
            end else if (!beat.valid && pop) begin
                fifo_cnt <= fifo_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        stg <= fifo_mem[rd_ptr];
        if (rst) begin
            stg.valid <= 1'b0;
        end else begin
            stg.valid <= pop;
        end
    end

    // Row-major block index.
    assign stg_blk = blk_w'((int'(stg.y) / cnn_feed_pkg::pool_dim) * cnn_feed_pkg::pool_grid
                            + int'(stg.x) / cnn_feed_pkg::pool_dim);

    always_comb begin
        acc_next = acc;
        if (stg.valid) begin
            acc_next[stg_blk] = acc[stg_blk] + cnn_feed_pkg::block_sum_t'(stg.data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            feat_valid <= 1'b0;
        end else if (stg.valid && stg.last) begin
            acc <= '0;              // Start clean for the next frame.
            feat_valid <= 1'b1;
        end else begin
            acc <= acc_next;
            if (feat_ready) begin
                feat_valid <= 1'b0;
            end
        end
    end

    // Cannot reload while pending since pops are held off.
    always_ff @(posedge clk) begin
        if (stg.valid && stg.last) begin
            feat.sums <= acc_next;
            feat.digit <= stg.digit;
        end
    end

endmodule

// File: logic/cnn_feed_top.sv
`timescale 1ns/1ps

module cnn_feed_top #(
    parameter int          credits = 4,
    parameter logic [15:0] gap_reset = 16'd16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  cnn_feed_pkg::cfg_wr_t  cfg_wr,
    output cnn_feed_pkg::feature_t feat,
    output logic                   feat_valid,
    input  logic                   feat_ready
);

    logic [15:0]              gap_cycles;
    cnn_feed_pkg::digit_seq_t digit_seq;
    cnn_feed_pkg::digit_t     glyph_digit;
    cnn_feed_pkg::coord_t     glyph_x;
    cnn_feed_pkg::coord_t     glyph_y;
    logic [7:0]               glyph_pix;
    cnn_feed_pkg::pix_beat_t  beat;
    logic                     credit_ret;

    feed_config #(
        .gap_reset(gap_reset)
    ) u_config (
        .clk(clk),
        .rst(rst),
        .cfg_wr(cfg_wr),
        .gap_cycles(gap_cycles),
        .digit_seq(digit_seq)
    );

    glyph_rom u_rom (
        .glyph_digit(glyph_digit),
        .glyph_x(glyph_x),
        .glyph_y(glyph_y),
        .glyph_pix(glyph_pix)
    );

    raster_scan #(
        .credits(credits)
    ) u_scan (
        .clk(clk),
        .rst(rst),
        .gap_cycles(gap_cycles),
        .digit_seq(digit_seq),
        .glyph_digit(glyph_digit),
        .glyph_x(glyph_x),
        .glyph_y(glyph_y),
        .glyph_pix(glyph_pix),
        .beat(beat),
        .credit_ret(credit_ret)
    );

    pool_sum #(
        .credits(credits)
    ) u_pool (
        .clk(clk),
        .rst(rst),
        .beat(beat),
        .credit_ret(credit_ret),
        .feat(feat),
        .feat_valid(feat_valid),
        .feat_ready(feat_ready)
    );

endmodule

// File: dv/tb_cnn_feed.sv
`timescale 1ns/1ps

module tb_cnn_feed;

    localparam int blocks = (cnn_feed_pkg::img_dim / cnn_feed_pkg::pool_dim) ** 2;
    localparam int frame_beats = cnn_feed_pkg::img_dim * cnn_feed_pkg::img_dim;
    localparam int num_tests = 5;

    typedef struct {
        logic        wr_en;
        logic        wr_addr;   // 0 gap, 1 sequence.
        logic [15:0] wr_data;
        logic        rand_rdy;
        int          gap;       // Gap in effect for this test's frames.
        logic        measure;   // Keep the last frame interval.
        int          frames;
        logic [3:0]  digits [6];
    } test_row_t;

    logic                   clk;
    logic                   rst;
    cnn_feed_pkg::cfg_wr_t  cfg_wr;
    cnn_feed_pkg::feature_t feat;
    logic                   feat_valid;
    logic                   feat_ready;

    test_row_t              tests [num_tests];
    cnn_feed_pkg::feature_t rx_feat [$];
    int                     rx_cycle [$];
    cnn_feed_pkg::feature_t held;
    logic                   hold_pending;
    logic                   rand_mode;
    int                     cycle;
    int                     limit;
    int                     check_cnt;
    int                     err_cnt;
    int                     hb;

    // Lit pixels per 10 by 10 block in row-major order from the glyph bitmaps.
    int one_cnt [9] = '{0, 17, 0, 0, 20, 0, 0, 16, 0};
    int two_cnt [9] = '{3, 13, 6, 3, 17, 0, 8, 20, 4};
    int eight_cnt [9] = '{11, 10, 11, 16, 12, 16, 1, 10, 1};

    cnn_feed_top #(
        .credits(4),
        .gap_reset(16'd16)
    ) uut (
        .clk(clk),
        .rst(rst),
        .cfg_wr(cfg_wr),
        .feat(feat),
        .feat_valid(feat_valid),
        .feat_ready(feat_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int lit_count(input logic [3:0] digit, input int blk);
        case (digit)
            4'd1:    return one_cnt[blk];
            4'd2:    return two_cnt[blk];
            4'd8:    return eight_cnt[blk];
            default: return 0;  // No glyph gives a blank frame.
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic write_cfg(input logic addr, input logic [15:0] data);
        @(posedge clk);
        cfg_wr.en <= 1'b1;
        cfg_wr.addr <= addr;
        if (addr) begin
            cfg_wr.data.seq <= data;
        end else begin
            cfg_wr.data.gap <= data;
        end
        @(posedge clk);
        cfg_wr.en <= 1'b0;
    endtask

    // Writes land in the gap after the previous frame, so they apply from the next frame.
    task automatic load_table;
        tests[0] = '{1'b0, 1'b0, 16'h0000, 1'b0, 16, 1'b1, 4, '{1, 2, 8, 1, 0, 0}};
        tests[1] = '{1'b1, 1'b1, 16'h1228, 1'b0, 16, 1'b0, 4, '{8, 2, 2, 1, 0, 0}};
        tests[2] = '{1'b1, 1'b1, 16'h2851, 1'b0, 16, 1'b0, 4, '{1, 5, 8, 2, 0, 0}};
        tests[3] = '{1'b1, 1'b0, 16'd200, 1'b0, 200, 1'b1, 3, '{1, 5, 8, 0, 0, 0}};
        tests[4] = '{1'b0, 1'b0, 16'h0000, 1'b1, 200, 1'b0, 5, '{2, 1, 5, 8, 2, 0}};
    endtask

    // Ready stays high unless the test asks for random.
    initial begin
        int seed_ret;
        seed_ret = $urandom(32'h1024);
        forever begin
            @(posedge clk);
            feat_ready <= rand_mode ? 1'($urandom % 2) : 1'b1;
        end
    end

    // Collects accepted features and checks feat holds while it waits.
    always @(negedge clk) begin
        cycle++;
        if (!rst) begin
            if (hold_pending) begin
                check_value("feat_valid", feat_valid, 1'b1);
                check_value("feat.digit", feat.digit, held.digit);
                for (hb = 0; hb < blocks; hb++) begin
                    check_value($sformatf("feat.sums[%0d]", hb), feat.sums[hb], held.sums[hb]);
                end
            end
            hold_pending = feat_valid && !feat_ready;
            held = feat;
            if (feat_valid && feat_ready) begin
                rx_feat.push_back(feat);
                rx_cycle.push_back(cycle);
            end
        end
    end

    initial begin
        wait (limit > 0);
        while (cycle < limit) begin
            @(negedge clk);
        end
        $display("Timeout: no complete run after %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int                     t;
        int                     f;
        int                     b;
        int                     errs_before;
        int                     failed;
        int                     prev_cyc;
        int                     cyc;
        int                     interval;
        int                     ref_interval;
        int                     ref_gap;
        logic                   ref_set;
        cnn_feed_pkg::feature_t got;

        clk = 1'b0;
        rst = 1'b1;
        cfg_wr = '0;
        feat_ready = 1'b1;
        rand_mode = 1'b0;
        hold_pending = 1'b0;
        cycle = 0;
        limit = 0;
        check_cnt = 0;
        err_cnt = 0;
        failed = 0;
        ref_set = 1'b0;
        ref_interval = 0;
        ref_gap = 0;

        load_table();
        limit = 16;
        for (t = 0; t < num_tests; t++) begin
            limit += tests[t].frames * (frame_beats + tests[t].gap + 50)
                     * (tests[t].rand_rdy ? 4 : 1);
        end

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (t = 0; t < num_tests; t++) begin
            errs_before = err_cnt;
            if (tests[t].wr_en) begin
                write_cfg(tests[t].wr_addr, tests[t].wr_data);
            end
            rand_mode = tests[t].rand_rdy;
            prev_cyc = 0;
            interval = 0;
            for (f = 0; f < tests[t].frames; f++) begin
                while (rx_feat.size() == 0) begin
                    @(negedge clk);
                end
                got = rx_feat.pop_front();
                cyc = rx_cycle.pop_front();
                check_value("feat.digit", got.digit, tests[t].digits[f]);
                for (b = 0; b < blocks; b++) begin
                    check_value($sformatf("feat.sums[%0d]", b), got.sums[b],
                                lit_count(tests[t].digits[f], b) * 255);
                end
                if (f > 0) begin
                    interval = cyc - prev_cyc;
                end
                prev_cyc = cyc;
            end
            // Frame and pooling latency are fixed, so only the gap moves the interval.
            if (tests[t].measure) begin
                if (!ref_set) begin
                    ref_interval = interval;
                    ref_gap = tests[t].gap;
                    ref_set = 1'b1;
                end else begin
                    check_value("frame interval delta", interval - ref_interval,
                                tests[t].gap - ref_gap);
                end
            end
            if (err_cnt != errs_before) begin
                failed++;
            end
            $display("test %0d: %0d frames, %0d mismatches", t, tests[t].frames,
                     err_cnt - errs_before);
        end

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 num_tests, failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: cnn_digit_feed.f
logic/cnn_feed_pkg.sv
logic/feed_config.sv
logic/glyph_rom.sv
logic/raster_scan.sv
logic/pool_sum.sv
logic/cnn_feed_top.sv
dv/tb_cnn_feed.sv
